//--- source/dac_pkg.sv
// shared constants and types for the AD5601 DAC controller
// imported by the RTL modules and by the testbench model
`default_nettype none

package dac_pkg;

    ////////////////////
    // widths
    ////////////////////

    // word address of the register bus
    localparam int reg_addr_w = 4;

    // data word and serial frame share one width
    localparam int dac_word_w = 16;

    // gain strobe from the loop
    localparam int gain_w   = 8;
    localparam int gain_lsb = 6;

    typedef logic [reg_addr_w-1:0] dac_addr_t;
    typedef logic [dac_word_w-1:0] dac_word_t;
    typedef logic [gain_w-1:0]     gain_t;

    ////////////////////
    // register map
    ////////////////////

    localparam dac_addr_t addr_module_id      = 4'd0;
    localparam dac_addr_t addr_module_version = 4'd1;
    localparam dac_addr_t addr_dac_reg        = 4'd2;
    // read-only copy of the control-select input
    localparam dac_addr_t addr_en_mmi_ctrl    = 4'd3;

    // decoded words, anything above reads zero
    localparam int num_regs = 4;

    localparam dac_word_t module_version = 16'd1;

endpackage

`default_nettype wire

//--- source/dac_reg_bank.sv
// register bank holding the DAC word, with bus strobes and the gain-field merge
// raises a one-cycle change pulse whenever the word is updated
`timescale 1ns/1ps
`default_nettype none

module dac_reg_bank
    import dac_pkg::*;
#(
    parameter dac_word_t MODULE_ID   = 16'h0000,
    parameter dac_word_t DAC_DEFAULT = 16'h0000
) (
    input  logic      clk_ifc,
    input  logic      set_default_on_reset,
    input  logic      en_mmi_ctrl,

    input  logic      reg_wr_stb,
    input  logic      reg_rd_stb,
    input  dac_addr_t reg_addr,
    input  dac_word_t reg_wdata,
    output dac_word_t reg_rdata,
    output logic      reg_rd_valid,

    input  logic      gain_stb,
    input  gain_t     gain,

    output dac_word_t dac_word,
    output logic      dac_word_changed
);

    dac_word_t rd_mux;
    dac_word_t gain_word;
    logic      wr_accept;
    logic      gain_accept;

    ////////////////////
    // update sources
    ////////////////////

    // bus owns the word while en_mmi_ctrl is high, the gain loop otherwise
    assign wr_accept   = reg_wr_stb && (reg_addr == addr_dac_reg) && en_mmi_ctrl;
    assign gain_accept = gain_stb && !en_mmi_ctrl;

    // gain replaces its field only, rest of the word kept
    always_comb begin
        gain_word = dac_word;
        gain_word[gain_lsb +: gain_w] = gain;
    end

    always_ff @(posedge clk_ifc) begin
        if (set_default_on_reset) begin
            dac_word         <= DAC_DEFAULT;
            dac_word_changed <= 1'b0;
        end else begin
            if (wr_accept) begin
                dac_word <= reg_wdata;
            end else if (gain_accept) begin
                dac_word <= gain_word;
            end
            // seen by the sequencer together with the new word
            dac_word_changed <= wr_accept | gain_accept;
        end
    end

    ////////////////////
    // read side
    ////////////////////

    always_comb begin
        rd_mux = '0;
        if (reg_addr < dac_addr_t'(num_regs)) begin
            case (reg_addr)
                addr_module_id:      rd_mux = MODULE_ID;
                addr_module_version: rd_mux = module_version;
                addr_dac_reg:        rd_mux = dac_word;
                addr_en_mmi_ctrl:    rd_mux = dac_word_t'(en_mmi_ctrl);
                default:             rd_mux = '0;
            endcase
        end
    end

    // one cycle read latency
    always_ff @(posedge clk_ifc) begin
        if (set_default_on_reset) begin
            reg_rd_valid <= 1'b0;
        end else begin
            reg_rd_valid <= reg_rd_stb;
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (reg_rd_stb) begin
            reg_rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

//--- source/dac_seq_ctrl.sv
// frame sequencing for the DAC: default frame after reset, one frame per change,
// and a single follow-up frame for changes that land while a frame is busy
`timescale 1ns/1ps
`default_nettype none

module dac_seq_ctrl
    import dac_pkg::*;
(
    input  logic      clk_ifc,
    input  logic      set_default_on_reset,

    input  logic      dac_word_changed,
    input  dac_word_t dac_word,

    input  logic      frame_done,
    output logic      frame_start,
    output dac_word_t frame_word,

    output logic      dac_updated_stb
);

    typedef enum logic [1:0] {
        st_launch,
        st_idle,
        st_busy
    } seq_state_t;

    seq_state_t state;
    logic       pending;

    ////////////////////
    // sequencing FSM
    ////////////////////

    always_ff @(posedge clk_ifc) begin
        if (set_default_on_reset) begin
            state       <= st_launch;
            frame_start <= 1'b0;
            pending     <= 1'b0;
        end else begin
            frame_start <= 1'b0;
            case (state)
                // bank still holds DAC_DEFAULT here
                st_launch: begin
                    frame_start <= 1'b1;
                    state       <= st_busy;
                end

                st_idle: begin
                    if (dac_word_changed) begin
                        frame_start <= 1'b1;
                        state       <= st_busy;
                    end
                end

                st_busy: begin
                    if (frame_done) begin
                        // any change seen during the frame, even on its last cycle
                        if (pending || dac_word_changed) begin
                            frame_start <= 1'b1;
                        end else begin
                            state <= st_idle;
                        end
                        pending <= 1'b0;
                    end else if (dac_word_changed) begin
                        pending <= 1'b1;
                    end
                end

                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // word sampled at the edge that raises frame_start
    always_ff @(posedge clk_ifc) begin
        if (state == st_launch ||
            (state == st_idle && dac_word_changed) ||
            (state == st_busy && frame_done && (pending || dac_word_changed))) begin
            frame_word <= dac_word;
        end
    end

    // end of every frame this block started
    assign dac_updated_stb = frame_done && (state == st_busy);

endmodule

`default_nettype wire

//--- source/spi_shift_tx.sv
// serial shifter for one 16-bit DAC frame, MSB first
// sdin changes with the rising sclk, the DAC samples on the falling one
`timescale 1ns/1ps
`default_nettype none

module spi_shift_tx
    import dac_pkg::*;
#(
    parameter int CLK_DIV = 4
) (
    input  logic      clk_ifc,
    input  logic      set_default_on_reset,

    input  logic      frame_start,
    input  dac_word_t frame_word,
    output logic      frame_done,

    output logic      sclk,
    output logic      sync_n,
    output logic      sdin
);

    localparam int div_w    = $clog2(CLK_DIV + 1);
    localparam int bit_w    = $clog2(dac_word_w);
    localparam int bit_last = dac_word_w - 1;

    logic [div_w-1:0] div_cnt;
    logic [bit_w-1:0] bit_cnt;
    dac_word_t        shift_reg;
    logic             phase_end;

    // last system cycle of the current sclk half period
    assign phase_end = (div_cnt == div_w'(CLK_DIV - 1));

    ////////////////////
    // frame timing
    ////////////////////

    always_ff @(posedge clk_ifc) begin
        if (set_default_on_reset) begin
            sync_n     <= 1'b1;
            sclk       <= 1'b0;
            sdin       <= 1'b0;
            frame_done <= 1'b0;
            div_cnt    <= '0;
            bit_cnt    <= '0;
        end else begin
            frame_done <= 1'b0;
            if (sync_n) begin
                if (frame_start) begin
                    // first bit goes out with sync_n
                    sync_n  <= 1'b0;
                    sclk    <= 1'b1;
                    sdin    <= frame_word[bit_last];
                    div_cnt <= '0;
                    bit_cnt <= '0;
                end
            end else if (!phase_end) begin
                div_cnt <= div_cnt + 1'b1;
            end else begin
                div_cnt <= '0;
                if (sclk) begin
                    sclk <= 1'b0;
                end else if (bit_cnt == bit_w'(bit_last)) begin
                    // low half of the last bit done
                    sync_n     <= 1'b1;
                    sdin       <= 1'b0;
                    frame_done <= 1'b1;
                end else begin
                    sclk    <= 1'b1;
                    sdin    <= shift_reg[bit_last];
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // remaining bits, next one at the top
    always_ff @(posedge clk_ifc) begin
        if (sync_n && frame_start) begin
            shift_reg <= frame_word << 1;
        end else if (!sync_n && phase_end && !sclk) begin
            shift_reg <= shift_reg << 1;
        end
    end

endmodule

`default_nettype wire

//--- source/dac_ctrl_top.sv
// top level of the AD5601 DAC controller
// ties the register bank, the frame sequencer and the serial shifter together
`timescale 1ns/1ps
`default_nettype none

module dac_ctrl_top
    import dac_pkg::*;
#(
    parameter dac_word_t MODULE_ID   = 16'h000a,
    parameter dac_word_t DAC_DEFAULT = 16'h0064,
    parameter int        CLK_DIV     = 4
) (
    input  logic      clk_ifc,
    input  logic      set_default_on_reset,
    input  logic      en_mmi_ctrl,

    input  logic      reg_wr_stb,
    input  logic      reg_rd_stb,
    input  dac_addr_t reg_addr,
    input  dac_word_t reg_wdata,
    output dac_word_t reg_rdata,
    output logic      reg_rd_valid,

    input  logic      gain_stb,
    input  gain_t     gain,

    output logic      dac_updated_stb,
    output logic      sclk,
    output logic      sync_n,
    output logic      sdin
);

    dac_word_t dac_word;
    logic      dac_word_changed;
    logic      frame_start;
    dac_word_t frame_word;
    logic      frame_done;

    dac_reg_bank #(
        .MODULE_ID   (MODULE_ID),
        .DAC_DEFAULT (DAC_DEFAULT)
    ) u_reg_bank (
        .clk_ifc              (clk_ifc),
        .set_default_on_reset (set_default_on_reset),
        .en_mmi_ctrl          (en_mmi_ctrl),
        .reg_wr_stb           (reg_wr_stb),
        .reg_rd_stb           (reg_rd_stb),
        .reg_addr             (reg_addr),
        .reg_wdata            (reg_wdata),
        .reg_rdata            (reg_rdata),
        .reg_rd_valid         (reg_rd_valid),
        .gain_stb             (gain_stb),
        .gain                 (gain),
        .dac_word             (dac_word),
        .dac_word_changed     (dac_word_changed)
    );

    dac_seq_ctrl u_seq_ctrl (
        .clk_ifc              (clk_ifc),
        .set_default_on_reset (set_default_on_reset),
        .dac_word_changed     (dac_word_changed),
        .dac_word             (dac_word),
        .frame_done           (frame_done),
        .frame_start          (frame_start),
        .frame_word           (frame_word),
        .dac_updated_stb      (dac_updated_stb)
    );

    spi_shift_tx #(
        .CLK_DIV (CLK_DIV)
    ) u_shift_tx (
        .clk_ifc              (clk_ifc),
        .set_default_on_reset (set_default_on_reset),
        .frame_start          (frame_start),
        .frame_word           (frame_word),
        .frame_done           (frame_done),
        .sclk                 (sclk),
        .sync_n               (sync_n),
        .sdin                 (sdin)
    );

endmodule

`default_nettype wire

//--- testbench/dac_ctrl_asserts.sv
// concurrent checks on the DAC serial pins and the one-cycle strobes
// bound into the controller top level, reports through failing assertions
`timescale 1ns/1ps
`default_nettype none

module dac_ctrl_asserts (
    input logic clk_ifc,
    input logic set_default_on_reset,
    input logic sclk,
    input logic sync_n,
    input logic dac_updated_stb,
    input logic reg_rd_valid
);

    // no clock towards the DAC outside a frame
    a_sclk_idle: assert property (@(posedge clk_ifc) disable iff (set_default_on_reset)
        sync_n |-> !sclk)
        else $error("sclk high while sync_n is high");

    a_updated_pulse: assert property (@(posedge clk_ifc) disable iff (set_default_on_reset)
        dac_updated_stb |=> !dac_updated_stb)
        else $error("dac_updated_stb longer than one cycle");

    a_rd_valid_pulse: assert property (@(posedge clk_ifc) disable iff (set_default_on_reset)
        reg_rd_valid |=> !reg_rd_valid)
        else $error("reg_rd_valid longer than one cycle");

    a_reset_sync: assert property (@(posedge clk_ifc) set_default_on_reset |=> sync_n)
        else $error("sync_n low during reset");

endmodule

bind dac_ctrl_top dac_ctrl_asserts u_asserts (
    .clk_ifc              (clk_ifc),
    .set_default_on_reset (set_default_on_reset),
    .sclk                 (sclk),
    .sync_n               (sync_n),
    .dac_updated_stb      (dac_updated_stb),
    .reg_rd_valid         (reg_rd_valid)
);

`default_nettype wire

//--- testbench/dac_ctrl_tb.sv
// testbench for the DAC controller: random register and gain traffic against a model
// serial frames are captured from the DAC pins and compared with the expected words
`timescale 1ns/1ps
`default_nettype none

module dac_ctrl_tb
    import dac_pkg::*;
();

    localparam dac_word_t tb_module_id   = 16'h5a01;
    localparam dac_word_t tb_dac_default = 16'h0a5c;
    localparam int        tb_clk_div     = 2;
    localparam int        num_ops        = 120;
    localparam int        timeout_cycles = num_ops * (32 * tb_clk_div + 40) + 200;

    logic      clk_ifc;
    logic      set_default_on_reset;
    logic      en_mmi_ctrl;
    logic      reg_wr_stb;
    logic      reg_rd_stb;
    dac_addr_t reg_addr;
    dac_word_t reg_wdata;
    dac_word_t reg_rdata;
    logic      reg_rd_valid;
    logic      gain_stb;
    gain_t     gain;
    logic      dac_updated_stb;
    logic      sclk;
    logic      sync_n;
    logic      sdin;

    // model state
    integer    seed;
    dac_word_t model_word;
    dac_word_t exp_frames[$];
    int        checked;
    int        value_errors;
    int        other_errors;

    // captured frames, written by the pin monitor only
    dac_word_t cap_words[$];
    int        cap_bits[$];
    logic      cap_upd[$];
    dac_word_t shift_in;
    int        bit_cnt;
    logic      prev_sclk   = 1'b0;
    logic      prev_sync_n = 1'b1;

    dac_ctrl_top #(
        .MODULE_ID   (tb_module_id),
        .DAC_DEFAULT (tb_dac_default),
        .CLK_DIV     (tb_clk_div)
    ) u_dut (
        .clk_ifc              (clk_ifc),
        .set_default_on_reset (set_default_on_reset),
        .en_mmi_ctrl          (en_mmi_ctrl),
        .reg_wr_stb           (reg_wr_stb),
        .reg_rd_stb           (reg_rd_stb),
        .reg_addr             (reg_addr),
        .reg_wdata            (reg_wdata),
        .reg_rdata            (reg_rdata),
        .reg_rd_valid         (reg_rd_valid),
        .gain_stb             (gain_stb),
        .gain                 (gain),
        .dac_updated_stb      (dac_updated_stb),
        .sclk                 (sclk),
        .sync_n               (sync_n),
        .sdin                 (sdin)
    );

    initial begin
        clk_ifc = 1'b0;
        forever #20 clk_ifc = ~clk_ifc;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk_ifc);
        $display("Timeout: the run did not finish within %0d clock cycles", timeout_cycles);
        $display("Result: FAILED");
        $finish;
    end

    ////////////////////
    // frame monitor
    ////////////////////

    // DAC side view, bit taken on the falling sclk
    always @(negedge clk_ifc) begin
        if (set_default_on_reset) begin
            bit_cnt = 0;
        end else begin
            if (!sync_n && prev_sclk && !sclk) begin
                shift_in = {shift_in[dac_word_w-2:0], sdin};
                bit_cnt  = bit_cnt + 1;
            end
            if (sync_n && !prev_sync_n) begin
                cap_words.push_back(shift_in);
                cap_bits.push_back(bit_cnt);
                cap_upd.push_back(dac_updated_stb);
                bit_cnt = 0;
            end
        end
        prev_sclk   = sclk;
        prev_sync_n = sync_n;
    end

    ////////////////////
    // checks
    ////////////////////

    task automatic check_word(input string name, input dac_word_t actual,
                              input dac_word_t expected);
        if (actual !== expected) begin
            $display("Fail %s: got %h, expected %h at %0t", name, actual, expected, $time);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("Fail %s: got %h, expected %h at %0t", name, actual, expected, $time);
            value_errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("Error: %s at %0t", msg, $time);
        other_errors++;
    endtask

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return lo + (r % (hi - lo + 1));
    endfunction

    function automatic dac_word_t model_read(input dac_addr_t addr);
        case (addr)
            4'd0:    return tb_module_id;
            4'd1:    return 16'h0001;
            4'd2:    return model_word;
            4'd3:    return {15'd0, en_mmi_ctrl};
            default: return 16'h0000;
        endcase
    endfunction

    task automatic check_new_frames();
        while (checked < cap_words.size()) begin
            if (checked >= exp_frames.size()) begin
                report_error("a frame was sent with no change to cause it");
            end else begin
                check_word("sdin frame", cap_words[checked], exp_frames[checked]);
            end
            if (cap_bits[checked] != dac_word_w) begin
                report_error("a frame did not carry 16 sclk periods");
            end
            check_flag("dac_updated_stb", cap_upd[checked], 1'b1);
            checked++;
        end
    endtask

    // until every expected frame has shown up on the pins
    task automatic wait_frames();
        do @(posedge clk_ifc); while (cap_words.size() < exp_frames.size());
        check_new_frames();
        @(negedge clk_ifc);
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    task automatic read_check(input dac_addr_t addr);
        dac_word_t expected;
        expected   = model_read(addr);
        reg_rd_stb = 1'b1;
        reg_addr   = addr;
        @(negedge clk_ifc);
        reg_rd_stb = 1'b0;
        check_flag("reg_rd_valid", reg_rd_valid, 1'b1);
        check_word("reg_rdata", reg_rdata, expected);
        @(negedge clk_ifc);
        check_flag("reg_rd_valid", reg_rd_valid, 1'b0);
    endtask

    task automatic bus_write(input dac_addr_t addr, input dac_word_t data,
                             output logic accepted);
        reg_wr_stb = 1'b1;
        reg_addr   = addr;
        reg_wdata  = data;
        @(negedge clk_ifc);
        reg_wr_stb = 1'b0;
        accepted   = (addr == 4'd2) && en_mmi_ctrl;
        if (accepted) begin
            model_word = data;
        end
    endtask

    task automatic gain_write(input gain_t value, output logic accepted);
        gain_stb = 1'b1;
        gain     = value;
        @(negedge clk_ifc);
        gain_stb = 1'b0;
        accepted = !en_mmi_ctrl;
        if (accepted) begin
            model_word = {model_word[15:14], value, model_word[5:0]};
        end
    endtask

    // change through whichever source owns the word
    task automatic random_change(output logic accepted);
        if (en_mmi_ctrl) begin
            bus_write(addr_dac_reg, dac_word_t'(rand_range(0, 65535)), accepted);
        end else begin
            gain_write(gain_t'(rand_range(0, 255)), accepted);
        end
    endtask

    task automatic settle(input logic accepted);
        if (accepted) begin
            exp_frames.push_back(model_word);
            wait_frames();
        end else begin
            repeat (4) @(negedge clk_ifc);
            check_flag("sync_n", sync_n, 1'b1);
            read_check(addr_dac_reg);
        end
    endtask

    initial begin
        logic      acc;
        int        n;
        dac_addr_t other;
        seed                 = 90;
        value_errors         = 0;
        other_errors         = 0;
        checked              = 0;
        set_default_on_reset = 1'b1;
        en_mmi_ctrl          = 1'b1;
        reg_wr_stb           = 1'b0;
        reg_rd_stb           = 1'b0;
        reg_addr             = '0;
        reg_wdata            = '0;
        gain_stb             = 1'b0;
        gain                 = '0;
        model_word           = tb_dac_default;
        exp_frames.push_back(tb_dac_default);
        repeat (10) @(posedge clk_ifc);
        @(negedge clk_ifc);
        set_default_on_reset = 1'b0;
        wait_frames();

        // random reads, control select flipped along the way
        for (int i = 0; i < 20; i++) begin
            en_mmi_ctrl = rand_range(0, 1) == 1;
            read_check(dac_addr_t'(rand_range(0, 15)));
        end

        // write rules for both owners of the word
        for (int i = 0; i < 4; i++) begin
            en_mmi_ctrl = 1'b1;
            bus_write(addr_dac_reg, dac_word_t'(rand_range(0, 65535)), acc);
            settle(acc);
            gain_write(gain_t'(rand_range(0, 255)), acc);
            settle(acc);
            other = dac_addr_t'(rand_range(0, 15));
            if (other == addr_dac_reg) begin
                other = addr_en_mmi_ctrl;
            end
            bus_write(other, dac_word_t'(rand_range(0, 65535)), acc);
            settle(acc);
            for (int a = 0; a < num_regs; a++) begin
                read_check(dac_addr_t'(a));
            end
            en_mmi_ctrl = 1'b0;
            bus_write(addr_dac_reg, dac_word_t'(rand_range(0, 65535)), acc);
            settle(acc);
            gain_write(gain_t'(rand_range(0, 255)), acc);
            settle(acc);
            read_check(addr_dac_reg);
        end

        // one frame per change when spaced out
        for (int i = 0; i < 10; i++) begin
            en_mmi_ctrl = rand_range(0, 1) == 1;
            random_change(acc);
            settle(acc);
        end

        // burst inside one busy frame, merged into a single follow-up
        for (int r = 0; r < 2; r++) begin
            en_mmi_ctrl = (r == 0);
            n = rand_range(2, 4);
            random_change(acc);
            exp_frames.push_back(model_word);
            for (int k = 0; k < n; k++) begin
                repeat (rand_range(3, 8)) @(negedge clk_ifc);
                random_change(acc);
            end
            exp_frames.push_back(model_word);
            wait_frames();
            read_check(addr_dac_reg);
            check_word("last frame", cap_words[cap_words.size() - 1], model_word);
        end

        // quiet bus, nothing else may go out
        repeat (80) @(posedge clk_ifc);
        check_new_frames();
        if (checked != exp_frames.size()) begin
            report_error("fewer frames were sent than changes called for");
        end
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dac_ctrl.f
source/dac_pkg.sv
source/dac_reg_bank.sv
source/dac_seq_ctrl.sv
source/spi_shift_tx.sv
source/dac_ctrl_top.sv
testbench/dac_ctrl_asserts.sv
testbench/dac_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the DAC controller testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module dac_ctrl_tb \
    -f dac_ctrl.f \
    -o sim_dac_ctrl

sim_out=$(./obj_dir/sim_dac_ctrl 2>&1) || true
echo "$sim_out"

if grep -qx "Result: PASSED" <<< "$sim_out"; then
    exit 0
fi
echo "simulation failed"
exit 1
